/* rtl/fp_isa_pkg.sv */
// ################################################
// FP ISA package
// RV32F opcode and funct encodings, instruction
// field positions, operation enum and FP constants
// ################################################
`default_nettype none

package fp_isa_pkg;

    // Data width and register file geometry
    localparam int unsigned FLEN       = 32;
    localparam int unsigned FREG_IDX_W = 5;
    localparam int unsigned FREG_NUM   = 32;

    // Major opcode for OP-FP
    localparam logic [6:0] OPC_OP_FP = 7'b1010011;

    // funct7 values, single precision only
    localparam logic [6:0] F7_FSGNJ   = 7'b0010000;
    localparam logic [6:0] F7_FMINMAX = 7'b0010100;

    // funct3 sub-encodings inside each funct7 group
    localparam logic [2:0] F3_SGNJ  = 3'b000;
    localparam logic [2:0] F3_SGNJN = 3'b001;
    localparam logic [2:0] F3_SGNJX = 3'b010;
    localparam logic [2:0] F3_MIN   = 3'b000;
    localparam logic [2:0] F3_MAX   = 3'b001;

    // Instruction field positions
    localparam int unsigned OPC_MSB = 6;
    localparam int unsigned OPC_LSB = 0;
    localparam int unsigned RD_MSB  = 11;
    localparam int unsigned RD_LSB  = 7;
    localparam int unsigned F3_MSB  = 14;
    localparam int unsigned F3_LSB  = 12;
    localparam int unsigned RS1_MSB = 19;
    localparam int unsigned RS1_LSB = 15;
    localparam int unsigned RS2_MSB = 24;
    localparam int unsigned RS2_LSB = 20;
    localparam int unsigned F7_MSB  = 31;
    localparam int unsigned F7_LSB  = 25;

    // Operations handled by the execute stage
    typedef enum logic [2:0] {
        OP_SGNJ  = 3'd0,
        OP_SGNJN = 3'd1,
        OP_SGNJX = 3'd2,
        OP_MIN   = 3'd3,
        OP_MAX   = 3'd4
    } fp_op_e;

    // Canonical quiet NaN
    localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc00000;

endpackage

`default_nettype wire

/* rtl/fp_pipe_pkg.sv */
// ################################################
// FP pipeline package
// Packed structs handed between decode, execute,
// result stage and register file
// ################################################
`default_nettype none

package fp_pipe_pkg;

    // Decoded op, output of the decode stage
    typedef struct packed {
        fp_isa_pkg::fp_op_e                  op;
        logic [fp_isa_pkg::FREG_IDX_W-1:0]   rs1;
        logic [fp_isa_pkg::FREG_IDX_W-1:0]   rs2;
        logic [fp_isa_pkg::FREG_IDX_W-1:0]   rd;
        logic                                illegal;
    } fp_dec_t;

    // Executed op, held by the result stage
    typedef struct packed {
        logic [fp_isa_pkg::FREG_IDX_W-1:0]   rd;
        logic [fp_isa_pkg::FLEN-1:0]         value;
        logic                                illegal;
    } fp_exe_t;

    // Write-back, also used as the bypass
    typedef struct packed {
        logic                                valid;
        logic [fp_isa_pkg::FREG_IDX_W-1:0]   rd;
        logic [fp_isa_pkg::FLEN-1:0]         value;
    } fp_wb_t;

endpackage

`default_nettype wire

/* rtl/fp_stage_reg.sv */
// ################################################
// FP stage register
// Valid bit plus payload, payload type is a
// parameter so one block serves every stage
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // Valid tracks the input on every edge
    // Payload only captured with a valid input, idle cycles keep it still
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                data_o <= data_i;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fp_decode.sv */
// ################################################
// FP decode stage
// Maps an RV32F word onto an operation, slices the
// register indices and registers the result
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_decode (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 instr_valid_i,
    input  logic [31:0]          instr_i,
    output logic                 dec_valid_o,
    output fp_pipe_pkg::fp_dec_t dec_o
);

    import fp_isa_pkg::*;
    import fp_pipe_pkg::*;

    // Raw instruction fields
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    // Decoded op before the stage register
    fp_dec_t    dec_d;

    assign opcode = instr_i[OPC_MSB:OPC_LSB];
    assign funct7 = instr_i[F7_MSB:F7_LSB];
    assign funct3 = instr_i[F3_MSB:F3_LSB];

    always_comb begin
        // Register indices are sliced for any word
        dec_d         = '0;
        dec_d.rs1     = instr_i[RS1_MSB:RS1_LSB];
        dec_d.rs2     = instr_i[RS2_MSB:RS2_LSB];
        dec_d.rd      = instr_i[RD_MSB:RD_LSB];
        // Illegal until a known encoding matches
        dec_d.op      = OP_SGNJ;
        dec_d.illegal = 1'b1;
        if (opcode == OPC_OP_FP) begin
            case (funct7)
                F7_FSGNJ: begin
                    // funct3 selects the sign source, no rounding mode here
                    case (funct3)
                        F3_SGNJ: begin
                            dec_d.op      = OP_SGNJ;
                            dec_d.illegal = 1'b0;
                        end
                        F3_SGNJN: begin
                            dec_d.op      = OP_SGNJN;
                            dec_d.illegal = 1'b0;
                        end
                        F3_SGNJX: begin
                            dec_d.op      = OP_SGNJX;
                            dec_d.illegal = 1'b0;
                        end
                        default: dec_d.illegal = 1'b1;
                    endcase
                end
                F7_FMINMAX: begin
                    // Only min and max exist in this group
                    case (funct3)
                        F3_MIN: begin
                            dec_d.op      = OP_MIN;
                            dec_d.illegal = 1'b0;
                        end
                        F3_MAX: begin
                            dec_d.op      = OP_MAX;
                            dec_d.illegal = 1'b0;
                        end
                        default: dec_d.illegal = 1'b1;
                    endcase
                end
                default: dec_d.illegal = 1'b1;
            endcase
        end
    end

    // Decode to execute register
    fp_stage_reg #(
        .payload_t(fp_dec_t)
    ) u_dec_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (instr_valid_i),
        .data_i  (dec_d),
        .valid_o (dec_valid_o),
        .data_o  (dec_o)
    );

endmodule

`default_nettype wire

/* rtl/fp_rf.sv */
// ################################################
// FP register file
// 32 x 32-bit, two operand reads and a peek read,
// one write port shared by write-back and load
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_rf (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  fp_pipe_pkg::fp_wb_t                  wb_i,
    input  logic                                 load_valid_i,
    input  logic [fp_isa_pkg::FREG_IDX_W-1:0]    load_idx_i,
    input  logic [fp_isa_pkg::FLEN-1:0]          load_value_i,
    input  logic [fp_isa_pkg::FREG_IDX_W-1:0]    rs1_idx_i,
    input  logic [fp_isa_pkg::FREG_IDX_W-1:0]    rs2_idx_i,
    output logic [fp_isa_pkg::FLEN-1:0]          rs1_value_o,
    output logic [fp_isa_pkg::FLEN-1:0]          rs2_value_o,
    input  logic [fp_isa_pkg::FREG_IDX_W-1:0]    peek_idx_i,
    output logic [fp_isa_pkg::FLEN-1:0]          peek_value_o
);

    import fp_isa_pkg::*;

    // Register storage, f0 is an ordinary register
    logic [FLEN-1:0] rf_q [FREG_NUM];

    // Synchronous write, write-back has priority over the host load
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < FREG_NUM; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_i.valid) begin
            rf_q[wb_i.rd] <= wb_i.value;
        end else if (load_valid_i) begin
            rf_q[load_idx_i] <= load_value_i;
        end
    end

    // Asynchronous operand reads
    assign rs1_value_o  = rf_q[rs1_idx_i];
    assign rs2_value_o  = rf_q[rs2_idx_i];

    // Host peek read
    assign peek_value_o = rf_q[peek_idx_i];

endmodule

`default_nettype wire

/* rtl/fp_execute.sv */
// ################################################
// FP execute stage
// Operand forwarding from the result stage, sign
// injection and IEEE 754 min/max
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_execute (
    input  logic                                 dec_valid_i,
    input  fp_pipe_pkg::fp_dec_t                 dec_i,
    output logic [fp_isa_pkg::FREG_IDX_W-1:0]    rs1_idx_o,
    output logic [fp_isa_pkg::FREG_IDX_W-1:0]    rs2_idx_o,
    input  logic [fp_isa_pkg::FLEN-1:0]          rs1_value_i,
    input  logic [fp_isa_pkg::FLEN-1:0]          rs2_value_i,
    input  fp_pipe_pkg::fp_wb_t                  bypass_i,
    output logic                                 exe_valid_o,
    output fp_pipe_pkg::fp_exe_t                 exe_o
);

    import fp_isa_pkg::*;

    // Operands after forwarding
    logic [FLEN-1:0] op_a;
    logic [FLEN-1:0] op_b;

    // NaN detection and ordering
    logic            a_nan;
    logic            b_nan;
    logic            a_lt_b;

    // Per-unit results
    logic [FLEN-1:0] sgnj_res;
    logic [FLEN-1:0] minmax_res;
    logic [FLEN-1:0] min_val;
    logic [FLEN-1:0] max_val;

    // Source indices straight to the register file
    assign rs1_idx_o = dec_i.rs1;
    assign rs2_idx_o = dec_i.rs2;

    // Result one instruction ahead overrides the stale register value
    assign op_a = (bypass_i.valid && (bypass_i.rd == dec_i.rs1)) ? bypass_i.value : rs1_value_i;
    assign op_b = (bypass_i.valid && (bypass_i.rd == dec_i.rs2)) ? bypass_i.value : rs2_value_i;

    // Exponent all ones with nonzero mantissa
    assign a_nan = (&op_a[30:23]) && (|op_a[22:0]);
    assign b_nan = (&op_b[30:23]) && (|op_b[22:0]);

    // Sign-magnitude compare, -0 ends up below +0
    always_comb begin
        if (op_a[31] != op_b[31]) begin
            a_lt_b = op_a[31];
        end else if (op_a[31]) begin
            // Both negative, larger magnitude is smaller
            a_lt_b = (op_a[30:0] > op_b[30:0]);
        end else begin
            a_lt_b = (op_a[30:0] < op_b[30:0]);
        end
    end

    assign min_val = a_lt_b ? op_a : op_b;
    assign max_val = a_lt_b ? op_b : op_a;

    // NaN handling, a single NaN yields the other operand
    always_comb begin
        if (a_nan && b_nan) begin
            minmax_res = CANON_NAN;
        end else if (a_nan) begin
            minmax_res = op_b;
        end else if (b_nan) begin
            minmax_res = op_a;
        end else if (dec_i.op == OP_MIN) begin
            minmax_res = min_val;
        end else begin
            minmax_res = max_val;
        end
    end

    // Sign injection keeps the magnitude of rs1
    always_comb begin
        case (dec_i.op)
            OP_SGNJN: sgnj_res = {~op_b[31], op_a[30:0]};
            OP_SGNJX: sgnj_res = {op_a[31] ^ op_b[31], op_a[30:0]};
            default:  sgnj_res = {op_b[31], op_a[30:0]};
        endcase
    end

    // Result select, zero for illegal ops
    always_comb begin
        exe_o.rd      = dec_i.rd;
        exe_o.illegal = dec_i.illegal;
        if (dec_i.illegal) begin
            exe_o.value = '0;
        end else if ((dec_i.op == OP_MIN) || (dec_i.op == OP_MAX)) begin
            exe_o.value = minmax_res;
        end else begin
            exe_o.value = sgnj_res;
        end
    end

    // No stalls, valid passes through the combinational stage
    assign exe_valid_o = dec_valid_i;

endmodule

`default_nettype wire

/* rtl/fp_result.sv */
// ################################################
// FP result stage
// Holds the executed op for one cycle and drives
// write-back, bypass and the result outputs
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_result (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 exe_valid_i,
    input  fp_pipe_pkg::fp_exe_t                 exe_i,
    output fp_pipe_pkg::fp_wb_t                  wb_o,
    output logic                                 res_valid_o,
    output logic                                 res_illegal_o,
    output logic [fp_isa_pkg::FREG_IDX_W-1:0]    res_rd_o,
    output logic [fp_isa_pkg::FLEN-1:0]          res_value_o
);

    import fp_pipe_pkg::*;

    // Registered executed op
    logic    exe_valid_q;
    fp_exe_t exe_q;

    fp_stage_reg #(
        .payload_t(fp_exe_t)
    ) u_exe_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (exe_valid_i),
        .data_i  (exe_i),
        .valid_o (exe_valid_q),
        .data_o  (exe_q)
    );

    // Illegal ops neither write nor forward
    assign wb_o.valid    = exe_valid_q && !exe_q.illegal;
    assign wb_o.rd       = exe_q.rd;
    assign wb_o.value    = exe_q.value;

    // Result report, value is already zero for illegal ops
    assign res_valid_o   = exe_valid_q;
    assign res_illegal_o = exe_q.illegal;
    assign res_rd_o      = exe_q.rd;
    assign res_value_o   = exe_q.value;

endmodule

`default_nettype wire

/* rtl/fp_unit_top.sv */
// ################################################
// FP unit top level
// Decode, execute and result stages around the
// FP register file, two cycle latency
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_unit_top (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    // Instruction strobe
    input  logic                                 instr_valid_i,
    input  logic [31:0]                          instr_i,
    // Host load port, only while the pipeline is empty
    input  logic                                 load_valid_i,
    input  logic [fp_isa_pkg::FREG_IDX_W-1:0]    load_idx_i,
    input  logic [fp_isa_pkg::FLEN-1:0]          load_value_i,
    // Peek port
    input  logic [fp_isa_pkg::FREG_IDX_W-1:0]    peek_idx_i,
    output logic [fp_isa_pkg::FLEN-1:0]          peek_value_o,
    // Result report
    output logic                                 res_valid_o,
    output logic                                 res_illegal_o,
    output logic [fp_isa_pkg::FREG_IDX_W-1:0]    res_rd_o,
    output logic [fp_isa_pkg::FLEN-1:0]          res_value_o
);

    import fp_isa_pkg::*;
    import fp_pipe_pkg::*;

    // Decode to execute
    logic            dec_valid;
    fp_dec_t         dec;

    // Execute to register file
    logic [FREG_IDX_W-1:0] rs1_idx;
    logic [FREG_IDX_W-1:0] rs2_idx;
    logic [FLEN-1:0]       rs1_value;
    logic [FLEN-1:0]       rs2_value;

    // Execute to result, and write-back loop
    logic            exe_valid;
    fp_exe_t         exe;
    fp_wb_t          wb;

    fp_decode u_fp_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    fp_rf u_fp_rf (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_i         (wb),
        .load_valid_i (load_valid_i),
        .load_idx_i   (load_idx_i),
        .load_value_i (load_value_i),
        .rs1_idx_i    (rs1_idx),
        .rs2_idx_i    (rs2_idx),
        .rs1_value_o  (rs1_value),
        .rs2_value_o  (rs2_value),
        .peek_idx_i   (peek_idx_i),
        .peek_value_o (peek_value_o)
    );

    fp_execute u_fp_execute (
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .rs1_idx_o   (rs1_idx),
        .rs2_idx_o   (rs2_idx),
        .rs1_value_i (rs1_value),
        .rs2_value_i (rs2_value),
        .bypass_i    (wb),
        .exe_valid_o (exe_valid),
        .exe_o       (exe)
    );

    fp_result u_fp_result (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .exe_valid_i   (exe_valid),
        .exe_i         (exe),
        .wb_o          (wb),
        .res_valid_o   (res_valid_o),
        .res_illegal_o (res_illegal_o),
        .res_rd_o      (res_rd_o),
        .res_value_o   (res_value_o)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// ################################################
// Testbench clock and reset
// 4 ns clock, active low reset held for 3 cycles
// ################################################
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // Free running clock, 2 ns per phase
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Release reset after three rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/fp_unit_sva.sv */
// ################################################
// FP unit assertions
// Fixed result latency, load port use and zero
// value on illegal results, bound into the top
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_unit_sva (
    input logic                         clk_i,
    input logic                         rst_n_i,
    input logic                         instr_valid_i,
    input logic                         dec_valid_i,
    input logic                         load_valid_i,
    input logic                         res_valid_i,
    input logic                         res_illegal_i,
    input logic [fp_isa_pkg::FLEN-1:0]  res_value_i
);

    // Failures so far, read by the testbench summary
    int unsigned fail_cnt = 0;

    // Result valid exactly two cycles after each instruction strobe
    a_res_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i == $past(instr_valid_i, 2))
    else begin
        $error("result valid does not follow the instruction strobe by 2 cycles");
        fail_cnt++;
    end

    // Host load only with an empty pipeline
    a_load_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_valid_i |-> !(instr_valid_i || dec_valid_i || res_valid_i))
    else begin
        $error("load port used while an instruction is in flight");
        fail_cnt++;
    end

    // Illegal results carry a zero value
    a_illegal_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_illegal_i |-> (res_value_i == '0))
    else begin
        $error("illegal result with a nonzero value");
        fail_cnt++;
    end

endmodule

bind fp_unit_top fp_unit_sva u_fp_unit_sva (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .dec_valid_i   (dec_valid),
    .load_valid_i  (load_valid_i),
    .res_valid_i   (res_valid_o),
    .res_illegal_i (res_illegal_o),
    .res_value_i   (res_value_o)
);

`default_nettype wire

/* dv/fp_unit_tb.sv */
// ################################################
// FP unit testbench
// Random and directed RV32F sign injection and
// min/max, program order model and scoreboard
// ################################################
`timescale 1ns/1ns
`default_nettype none

module fp_unit_tb;

    import fp_isa_pkg::*;

    // Expected result for one issued word
    typedef struct packed {
        logic [FREG_IDX_W-1:0] rd;
        logic [FLEN-1:0]       value;
        logic                  illegal;
    } exp_t;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  load_valid;
    logic [FREG_IDX_W-1:0] load_idx;
    logic [FLEN-1:0]       load_value;
    logic [FREG_IDX_W-1:0] peek_idx;
    logic [FLEN-1:0]       peek_value;
    logic                  res_valid;
    logic                  res_illegal;
    logic [FREG_IDX_W-1:0] res_rd;
    logic [FLEN-1:0]       res_value;

    // Register model in program order and pending results
    logic [FLEN-1:0] model_rf [FREG_NUM];
    exp_t            exp_q [$];
    int unsigned     err_cnt = 0;

    tb_clk_gen u_tb_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fp_unit_top u_fp_unit_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .load_valid_i  (load_valid),
        .load_idx_i    (load_idx),
        .load_value_i  (load_value),
        .peek_idx_i    (peek_idx),
        .peek_value_o  (peek_value),
        .res_valid_o   (res_valid),
        .res_illegal_o (res_illegal),
        .res_rd_o      (res_rd),
        .res_value_o   (res_value)
    );

    function automatic logic is_nan(input logic [FLEN-1:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    // Unsigned key order follows float order with -0 just below +0
    function automatic logic [FLEN-1:0] order_key(input logic [FLEN-1:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [FLEN-1:0] ref_exec(input fp_op_e op,
                                                 input logic [FLEN-1:0] a,
                                                 input logic [FLEN-1:0] b);
        logic            a_below;
        logic [FLEN-1:0] res;
        a_below = order_key(a) < order_key(b);
        case (op)
            OP_SGNJ:  res = {b[31], a[30:0]};
            OP_SGNJN: res = {!b[31], a[30:0]};
            OP_SGNJX: res = {a[31] ^ b[31], a[30:0]};
            default: begin
                // NaN rules first and plain ordering after them
                if (is_nan(a) && is_nan(b)) begin
                    res = CANON_NAN;
                end else if (is_nan(a)) begin
                    res = b;
                end else if (is_nan(b)) begin
                    res = a;
                end else if (op == OP_MIN) begin
                    res = a_below ? a : b;
                end else begin
                    res = a_below ? b : a;
                end
            end
        endcase
        return res;
    endfunction

    function automatic logic [31:0] make_word(input fp_op_e op,
                                              input logic [FREG_IDX_W-1:0] rd,
                                              input logic [FREG_IDX_W-1:0] rs1,
                                              input logic [FREG_IDX_W-1:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = ((op == OP_MIN) || (op == OP_MAX)) ? F7_FMINMAX : F7_FSGNJ;
        case (op)
            OP_SGNJN: f3 = F3_SGNJN;
            OP_SGNJX: f3 = F3_SGNJX;
            OP_MIN:   f3 = F3_MIN;
            OP_MAX:   f3 = F3_MAX;
            default:  f3 = F3_SGNJ;
        endcase
        return {f7, rs2, rs1, f3, rd, OPC_OP_FP};
    endfunction

    // Kind 0 carries the integer OP opcode
    // Kind 1 carries an unknown funct7
    // Other kinds are the FMIN group with funct3 2
    function automatic logic [31:0] bad_word(input int kind,
                                             input logic [FREG_IDX_W-1:0] rd,
                                             input logic [FREG_IDX_W-1:0] rs1,
                                             input logic [FREG_IDX_W-1:0] rs2);
        logic [31:0] w;
        case (kind)
            0:       w = {F7_FSGNJ, rs2, rs1, F3_SGNJ, rd, 7'b0110011};
            1:       w = {7'b1111111, rs2, rs1, 3'b000, rd, OPC_OP_FP};
            default: w = {F7_FMINMAX, rs2, rs1, 3'b010, rd, OPC_OP_FP};
        endcase
        return w;
    endfunction

    function automatic logic [FREG_IDX_W-1:0] rand_idx();
        return FREG_IDX_W'($urandom_range(FREG_NUM - 1, 0));
    endfunction

    function automatic fp_op_e rand_op();
        return fp_op_e'($urandom_range(4, 0));
    endfunction

    // Random pattern with NaN, infinity and zero mixed in
    function automatic logic [FLEN-1:0] rand_fp();
        logic [FLEN-1:0] v;
        v = $urandom();
        case ($urandom_range(7, 0))
            0:       v[30:23] = 8'hff;
            1:       v[30:0] = '0;
            default: v = v;
        endcase
        return v;
    endfunction

    task automatic check_val(input logic [FLEN-1:0] got, input logic [FLEN-1:0] exp_v,
                             input string what);
        if (got !== exp_v) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s mismatch, got %h, expected %h", $time, what, got,
                     exp_v);
        end
    endtask

    task automatic issue_op(input fp_op_e op, input logic [FREG_IDX_W-1:0] rd,
                            input logic [FREG_IDX_W-1:0] rs1,
                            input logic [FREG_IDX_W-1:0] rs2);
        exp_t e;
        e.rd      = rd;
        e.illegal = 1'b0;
        e.value   = ref_exec(op, model_rf[rs1], model_rf[rs2]);
        model_rf[rd] = e.value;
        exp_q.push_back(e);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= make_word(op, rd, rs1, rs2);
    endtask

    // Illegal word leaves rd at its old value
    task automatic issue_bad(input int kind, input logic [FREG_IDX_W-1:0] rd,
                             input logic [FREG_IDX_W-1:0] rs1,
                             input logic [FREG_IDX_W-1:0] rs2);
        exp_t e;
        e.rd      = rd;
        e.illegal = 1'b1;
        e.value   = '0;
        exp_q.push_back(e);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= bad_word(kind, rd, rs1, rs2);
    endtask

    task automatic idle(input int unsigned cycles);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // Stop issuing and wait until every result came out and was written
    task automatic drain();
        int unsigned waited;
        waited = 0;
        @(posedge clk);
        instr_valid <= 1'b0;
        while ((exp_q.size() != 0) && (waited < 20)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("Timeout: %0d results never left the pipeline", exp_q.size());
            exp_q.delete();
        end
        @(posedge clk);
    endtask

    task automatic load_reg(input logic [FREG_IDX_W-1:0] idx, input logic [FLEN-1:0] val);
        model_rf[idx] = val;
        @(posedge clk);
        load_valid <= 1'b1;
        load_idx   <= idx;
        load_value <= val;
    endtask

    task automatic load_end();
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    task automatic peek_check(input logic [FREG_IDX_W-1:0] idx);
        @(posedge clk);
        peek_idx <= idx;
        @(negedge clk);
        check_val(peek_value, model_rf[idx], $sformatf("peek f%0d", idx));
    endtask

    task automatic peek_all();
        for (int i = 0; i < FREG_NUM; i++) begin
            peek_check(FREG_IDX_W'(i));
        end
    endtask

    // Scoreboard samples the outputs mid-cycle
    initial begin : compare_results
        exp_t exp_v;
        forever begin
            @(negedge clk);
            if (res_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Result for f%0d came out with no instruction pending", res_rd);
                end else begin
                    exp_v = exp_q.pop_front();
                    check_val(res_rd, exp_v.rd, "result rd");
                    check_val(res_value, exp_v.value, "result value");
                    check_val(res_illegal, exp_v.illegal, "result illegal flag");
                end
            end
        end
    end

    initial begin : stimulus
        int unsigned           waited;
        int unsigned           sva_fails;
        int                    pair_a [8];
        int                    pair_b [8];
        logic [FREG_IDX_W-1:0] rd;
        logic [FREG_IDX_W-1:0] prev_rd;
        void'($urandom(32'hf8e4_dafc));
        instr_valid = 1'b0;
        instr       = '0;
        load_valid  = 1'b0;
        load_idx    = '0;
        load_value  = '0;
        peek_idx    = '0;
        for (int i = 0; i < FREG_NUM; i++) begin
            model_rf[i] = '0;
        end

        waited = 0;
        while ((rst_n !== 1'b1) && (waited < 20)) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            err_cnt++;
            $display("Timeout: reset was never released");
        end

        // Registers read zero after reset and no result appears
        for (int i = 0; i < FREG_NUM; i++) begin
            peek_check(FREG_IDX_W'(i));
            check_val(res_valid, 1'b0, "res_valid after reset");
        end

        // Random fill followed by sign injection one at a time
        for (int i = 0; i < FREG_NUM; i++) begin
            load_reg(FREG_IDX_W'(i), rand_fp());
        end
        load_end();
        repeat (24) begin
            rd = rand_idx();
            issue_op(fp_op_e'($urandom_range(2, 0)), rd, rand_idx(), rand_idx());
            drain();
            peek_check(rd);
        end

        // Directed min/max on +-0, one NaN, two NaNs, equal values and infinity
        load_reg(1, 32'h0000_0000);
        load_reg(2, 32'h8000_0000);
        load_reg(3, 32'h7f80_0001);
        load_reg(4, 32'hffc0_0000);
        load_reg(5, 32'h3f80_0000);
        load_reg(6, 32'hbf80_0000);
        load_reg(7, 32'h3f80_0000);
        load_reg(8, 32'h7f80_0000);
        load_end();
        pair_a = '{1, 2, 3, 5, 3, 5, 5, 6};
        pair_b = '{2, 1, 5, 3, 4, 7, 6, 8};
        for (int k = 0; k < 8; k++) begin
            issue_op(OP_MIN, FREG_IDX_W'(16 + k), FREG_IDX_W'(pair_a[k]),
                     FREG_IDX_W'(pair_b[k]));
            issue_op(OP_MAX, FREG_IDX_W'(24 + k), FREG_IDX_W'(pair_a[k]),
                     FREG_IDX_W'(pair_b[k]));
        end
        drain();
        peek_all();

        // Random min/max on fresh values
        for (int i = 0; i < FREG_NUM; i++) begin
            load_reg(FREG_IDX_W'(i), rand_fp());
        end
        load_end();
        repeat (32) begin
            issue_op(fp_op_e'($urandom_range(4, 3)), rand_idx(), rand_idx(), rand_idx());
        end
        drain();
        peek_all();

        // Dependent chain where each rs1 is the previous rd
        prev_rd = rand_idx();
        issue_op(rand_op(), prev_rd, rand_idx(), rand_idx());
        repeat (10) begin
            rd = rand_idx();
            issue_op(rand_op(), rd, prev_rd, rand_idx());
            prev_rd = rd;
        end
        rd = rand_idx();
        issue_op(OP_SGNJX, rd, prev_rd, prev_rd);
        issue_op(OP_MAX, rand_idx(), rd, rd);
        drain();
        peek_all();

        // Illegal words followed by a dependent op that must see the old rd
        for (int kind = 0; kind < 3; kind++) begin
            rd = FREG_IDX_W'(10 + kind);
            // Negative nonzero old value so a zero write or bypass stands out
            load_reg(rd, 32'hc049_0fdb);
            load_end();
            issue_bad(kind, rd, rand_idx(), rand_idx());
            issue_op(OP_SGNJ, FREG_IDX_W'(20 + kind), rd, rd);
            drain();
            peek_check(rd);
            peek_check(FREG_IDX_W'(20 + kind));
        end

        // Long random mix with gaps
        repeat (200) begin
            if ($urandom_range(6, 0) == 0) begin
                issue_bad($urandom_range(2, 0), rand_idx(), rand_idx(), rand_idx());
            end else begin
                issue_op(rand_op(), rand_idx(), rand_idx(), rand_idx());
            end
            idle($urandom_range(2, 0));
        end
        drain();
        peek_all();

        sva_fails = u_fp_unit_top.u_fp_unit_sva.fail_cnt;
        $display("Summary: %0d check errors, %0d assertion failures", err_cnt, sva_fails);
        if ((err_cnt == 0) && (sva_fails == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rtl/fp_isa_pkg.sv
rtl/fp_pipe_pkg.sv
rtl/fp_stage_reg.sv
rtl/fp_decode.sv
rtl/fp_rf.sv
rtl/fp_execute.sv
rtl/fp_result.sv
rtl/fp_unit_top.sv
dv/tb_clk_gen.sv
dv/fp_unit_sva.sv
dv/fp_unit_tb.sv

/* Bender.yml */
package:
  name: fp_unit

sources:
  - rtl/fp_isa_pkg.sv
  - rtl/fp_pipe_pkg.sv
  - rtl/fp_stage_reg.sv
  - rtl/fp_decode.sv
  - rtl/fp_rf.sv
  - rtl/fp_execute.sv
  - rtl/fp_result.sv
  - rtl/fp_unit_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/fp_unit_sva.sv
      - dv/fp_unit_tb.sv
